/* verilog/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // ==============================
    // basic widths
    // ==============================

    typedef logic [7:0]  byte_t;
    typedef logic [23:0] wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    // one classic bus cycle as seen by the peripheral
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t wdata;
    } wb_req_t;

    // status word, rx_avail lands in bit 0
    typedef struct packed {
        logic frame_err;
        logic tx_not_full;
        logic rx_avail;
    } uart_status_t;

    // ==============================
    // register map
    // ==============================

    localparam wb_adr_t ADR_STATUS  = 24'h00_0000;
    localparam wb_adr_t ADR_TX_DATA = 24'h00_0002;
    localparam wb_adr_t ADR_RX_DATA = 24'h00_0004;

    // idle bit periods the tx line rests after each stop bit
    localparam int HOLD_BITS = 8;

    // ==============================
    // state machines
    // ==============================

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_HOLD
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_byte_fifo.sv */
`default_nettype none

module uart_byte_fifo #(
    parameter int DEPTH = 8
) (
    input  wire                 uart_clk,
    input  wire                 i_rst,
    input  wire                 push,
    input  wire uart_pkg::byte_t push_data,
    input  wire                 pop,
    output uart_pkg::byte_t     head_data,
    output logic                empty,
    output logic                full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_pkg::byte_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // requests against a full or empty buffer are simply dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign head_data = mem[rd_ptr];

    always_ff @(posedge uart_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge uart_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap explicitly so DEPTH need not be a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_bus_regs.sv */
`default_nettype none

module uart_bus_regs (
    input  wire                   uart_clk,
    input  wire                   i_rst,

    input  wire uart_pkg::wb_req_t wb_req,
    output logic                  wb_ack,
    output uart_pkg::wb_dat_t     wb_rdata,

    output logic                  tx_push,
    output uart_pkg::byte_t       tx_byte,
    input  wire                   tx_full,

    output logic                  rx_pop,
    input  wire uart_pkg::byte_t   rx_byte,
    input  wire                   rx_empty,

    input  wire                   frame_err_pulse
);

    logic                   bus_write;
    logic                   bus_read;
    logic                   frame_err;
    uart_pkg::uart_status_t status;

    // ==============================
    // bus decode
    // ==============================

    // ack comes back in the same cycle as the strobe
    assign wb_ack    = wb_req.cyc & wb_req.stb;
    assign bus_write = wb_ack & wb_req.we;
    assign bus_read  = wb_ack & ~wb_req.we;

    // a write into a full FIFO is acked and then dropped by the FIFO
    assign tx_push = bus_write & (wb_req.adr == uart_pkg::ADR_TX_DATA);
    assign tx_byte = wb_req.wdata[7:0];

    // popping an empty rx FIFO is harmless, the FIFO ignores it
    assign rx_pop = bus_read & (wb_req.adr == uart_pkg::ADR_RX_DATA);

    // ==============================
    // sticky framing error
    // ==============================

    always_ff @(posedge uart_clk) begin
        if (i_rst) begin
            frame_err <= 1'b0;
        end else if (frame_err_pulse) begin
            // a new error beats a clear arriving in the same cycle
            frame_err <= 1'b1;
        end else if (bus_write && wb_req.adr == uart_pkg::ADR_STATUS) begin
            frame_err <= 1'b0;
        end
    end

    // ==============================
    // read data
    // ==============================

    always_comb begin
        status.rx_avail    = ~rx_empty;
        status.tx_not_full = ~tx_full;
        status.frame_err   = frame_err;
    end

    always_comb begin
        case (wb_req.adr)
            uart_pkg::ADR_STATUS: begin
                wb_rdata = {13'd0, status};
            end
            uart_pkg::ADR_RX_DATA: begin
                wb_rdata = rx_empty ? 16'd0 : {8'd0, rx_byte};
            end
            default: begin
                wb_rdata = 16'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/uart_tx_serializer.sv */
`default_nettype none

module uart_tx_serializer #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire                 uart_clk,
    input  wire                 i_rst,
    input  wire                 fifo_empty,
    input  wire uart_pkg::byte_t fifo_data,
    output logic                fifo_pop,
    output logic                tx
);

    localparam int CNT_W  = $clog2(CLKS_PER_BIT);
    localparam int HOLD_W = $clog2(uart_pkg::HOLD_BITS + 1);

    uart_pkg::tx_state_t state;
    logic [CNT_W-1:0]    clk_cnt;
    logic [2:0]          bit_idx;
    logic [HOLD_W-1:0]   hold_cnt;
    uart_pkg::byte_t     shift;
    logic                bit_done;

    // head byte leaves the FIFO in the same cycle it is latched
    assign fifo_pop = (state == uart_pkg::TX_IDLE) & ~fifo_empty;
    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge uart_clk) begin
        if (fifo_pop) begin
            shift <= fifo_data;
        end else if (bit_done && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge uart_clk) begin
        if (i_rst) begin
            state    <= uart_pkg::TX_IDLE;
            tx       <= 1'b1;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            hold_cnt <= '0;
        end else begin
            clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    clk_cnt <= '0;
                    if (fifo_pop) begin
                        tx    <= 1'b0;
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        tx      <= shift[0];
                        bit_idx <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            tx      <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_done) begin
                        hold_cnt <= '0;
                        state    <= uart_pkg::TX_HOLD;
                    end
                end
                uart_pkg::TX_HOLD: begin
                    // line rests high for HOLD_BITS whole bit periods
                    if (bit_done) begin
                        hold_cnt <= hold_cnt + 1'b1;
                        if (hold_cnt == HOLD_W'(uart_pkg::HOLD_BITS - 1)) begin
                            state <= uart_pkg::TX_IDLE;
                        end
                    end
                end
                default: begin
                    tx    <= 1'b1;
                    state <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_rx_deserializer.sv */
`default_nettype none

module uart_rx_deserializer #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire             uart_clk,
    input  wire             i_rst,
    input  wire             rx,
    output logic            byte_valid,
    output uart_pkg::byte_t byte_data,
    output logic            frame_err_pulse
);

    localparam int CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    uart_pkg::rx_state_t state;
    logic                rx_meta;
    logic                rx_sync;
    logic [CNT_W-1:0]    clk_cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shift;
    logic                half_done;
    logic                bit_done;

    // ==============================
    // input synchronizer
    // ==============================

    always_ff @(posedge uart_clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ==============================
    // frame state machine
    // ==============================

    assign half_done = (clk_cnt == CNT_W'(HALF_BIT - 1));
    assign bit_done  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign byte_data = shift;

    // data bits arrive LSB first, so shift in from the top
    always_ff @(posedge uart_clk) begin
        if (state == uart_pkg::RX_DATA && bit_done) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    always_ff @(posedge uart_clk) begin
        if (i_rst) begin
            state           <= uart_pkg::RX_IDLE;
            clk_cnt         <= '0;
            bit_idx         <= '0;
            byte_valid      <= 1'b0;
            frame_err_pulse <= 1'b0;
        end else begin
            byte_valid      <= 1'b0;
            frame_err_pulse <= 1'b0;
            clk_cnt         <= clk_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    // recheck half a bit later to reject glitches
                    if (half_done) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_done) begin
                        byte_valid      <= rx_sync;
                        frame_err_pulse <= ~rx_sync;
                        state           <= uart_pkg::RX_IDLE;
                    end
                end
                default: begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_top.sv */
`default_nettype none

module uart_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int TX_DEPTH     = 8,
    parameter int RX_DEPTH     = 4
) (
    input  wire                   uart_clk,
    input  wire                   i_rst,
    input  wire uart_pkg::wb_req_t wb_req,
    output logic                  wb_ack,
    output uart_pkg::wb_dat_t     wb_rdata,
    input  wire                   rx,
    output logic                  tx
);

    logic            tx_push;
    uart_pkg::byte_t tx_byte;
    logic            tx_pop;
    uart_pkg::byte_t tx_head;
    logic            tx_empty;
    logic            tx_full;

    logic            rx_push;
    uart_pkg::byte_t rx_byte;
    logic            rx_pop;
    uart_pkg::byte_t rx_head;
    logic            rx_empty;

    logic            frame_err_pulse;

    // ==============================
    // bus side
    // ==============================

    uart_bus_regs u_bus_regs (
        .uart_clk        (uart_clk),
        .i_rst           (i_rst),
        .wb_req          (wb_req),
        .wb_ack          (wb_ack),
        .wb_rdata        (wb_rdata),
        .tx_push         (tx_push),
        .tx_byte         (tx_byte),
        .tx_full         (tx_full),
        .rx_pop          (rx_pop),
        .rx_byte         (rx_head),
        .rx_empty        (rx_empty),
        .frame_err_pulse (frame_err_pulse)
    );

    // ==============================
    // buffering
    // ==============================

    uart_byte_fifo #(
        .DEPTH (TX_DEPTH)
    ) tx_fifo (
        .uart_clk  (uart_clk),
        .i_rst     (i_rst),
        .push      (tx_push),
        .push_data (tx_byte),
        .pop       (tx_pop),
        .head_data (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    // the serial line cannot be held off so nothing uses this full flag
    uart_byte_fifo #(
        .DEPTH (RX_DEPTH)
    ) rx_fifo (
        .uart_clk  (uart_clk),
        .i_rst     (i_rst),
        .push      (rx_push),
        .push_data (rx_byte),
        .pop       (rx_pop),
        .head_data (rx_head),
        .empty     (rx_empty),
        .full      ()
    );

    // ==============================
    // serial side
    // ==============================

    uart_tx_serializer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx_serializer (
        .uart_clk   (uart_clk),
        .i_rst      (i_rst),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_head),
        .fifo_pop   (tx_pop),
        .tx         (tx)
    );

    uart_rx_deserializer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx_deserializer (
        .uart_clk        (uart_clk),
        .i_rst           (i_rst),
        .rx              (rx),
        .byte_valid      (rx_push),
        .byte_data       (rx_byte),
        .frame_err_pulse (frame_err_pulse)
    );

endmodule

`default_nettype wire

/* verification/uart_tb.sv */
`default_nettype none

module uart_tb;

    localparam int CLKS_PER_BIT    = 16;
    localparam int TX_DEPTH        = 8;
    localparam int RX_DEPTH        = 4;
    localparam int HALF_PERIOD     = 50;
    localparam int HALF_BIT        = CLKS_PER_BIT / 2;
    localparam int NUM_VECS        = 7;
    localparam int NUM_FRAMES      = NUM_VECS + (TX_DEPTH + 3) + (RX_DEPTH + 2);
    localparam int WATCHDOG_CYCLES =
        (NUM_FRAMES * (10 + uart_pkg::HOLD_BITS) + 64) * CLKS_PER_BIT;

    // expected is the decoded tx byte, the rx read data, or the status after a bad frame
    typedef struct packed {
        uart_pkg::byte_t   data;
        logic              to_rx;
        logic              bad_stop;
        uart_pkg::wb_dat_t expected;
    } vec_t;

    logic              uart_clk;
    logic              i_rst;
    uart_pkg::wb_req_t wb_req;
    logic              wb_ack;
    uart_pkg::wb_dat_t wb_rdata;
    logic              rx;
    logic              tx;

    vec_t              vecs [NUM_VECS];
    uart_pkg::byte_t   tx_seen [$];
    uart_pkg::byte_t   expected_q [$];
    uart_pkg::byte_t   b;
    int                fifo_level;
    int                error_count = 0;
    integer            seed = 32'h0babf8f0;

    uart_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .TX_DEPTH     (TX_DEPTH),
        .RX_DEPTH     (RX_DEPTH)
    ) dut (
        .uart_clk (uart_clk),
        .i_rst    (i_rst),
        .wb_req   (wb_req),
        .wb_ack   (wb_ack),
        .wb_rdata (wb_rdata),
        .rx       (rx),
        .tx       (tx)
    );

    always #HALF_PERIOD uart_clk = ~uart_clk;

    // ==============================
    // helpers
    // ==============================

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // one classic cycle, ack is combinational so the access ends at the next edge
    task automatic access_bus(input logic we, input uart_pkg::wb_adr_t adr,
                              input uart_pkg::wb_dat_t wdata, output uart_pkg::wb_dat_t data);
        uart_pkg::wb_req_t req;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.adr   = adr;
        req.wdata = wdata;
        @(posedge uart_clk);
        wb_req <= req;
        @(negedge uart_clk);
        data = wb_rdata;
        check_value({15'd0, wb_ack}, 16'h0001, "wb_ack during bus cycle");
        @(posedge uart_clk);
        wb_req <= '0;
    endtask

    task automatic write_reg(input uart_pkg::wb_adr_t adr, input uart_pkg::wb_dat_t wdata);
        uart_pkg::wb_dat_t unused;
        access_bus(1'b1, adr, wdata, unused);
    endtask

    task automatic expect_read(input uart_pkg::wb_adr_t adr, input uart_pkg::wb_dat_t expected,
                               input string what);
        uart_pkg::wb_dat_t data;
        access_bus(1'b0, adr, 16'h0000, data);
        check_value(data, expected, what);
    endtask

    task automatic drive_rx_bit(input logic level, input int cycles);
        rx <= level;
        repeat (cycles) @(posedge uart_clk);
    endtask

    // a corrupt stop bit is low only across its middle so no false start follows it
    task automatic send_rx_frame(input uart_pkg::byte_t value, input logic bad_stop);
        int i;
        @(posedge uart_clk);
        drive_rx_bit(1'b0, CLKS_PER_BIT);
        for (i = 0; i < 8; i++) begin
            drive_rx_bit(value[i], CLKS_PER_BIT);
        end
        if (bad_stop) begin
            drive_rx_bit(1'b0, CLKS_PER_BIT * 3 / 4);
            drive_rx_bit(1'b1, CLKS_PER_BIT / 4);
        end else begin
            drive_rx_bit(1'b1, CLKS_PER_BIT);
        end
        drive_rx_bit(1'b1, 2 * CLKS_PER_BIT);
    endtask

    task automatic decode_tx_frame(output uart_pkg::byte_t value);
        int i;
        @(negedge uart_clk);
        while (tx !== 1'b0) begin
            @(negedge uart_clk);
        end
        repeat (HALF_BIT) @(negedge uart_clk);
        check_value({15'd0, tx}, 16'h0000, "tx start bit");
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge uart_clk);
            value[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge uart_clk);
        check_value({15'd0, tx}, 16'h0001, "tx stop bit");
    endtask

    task automatic take_tx_byte(output uart_pkg::byte_t value);
        while (tx_seen.size() == 0) begin
            @(negedge uart_clk);
        end
        value = tx_seen.pop_front();
    endtask

    // long enough for a queued frame to follow the guard time and be fully decoded
    task automatic wait_tx_idle();
        repeat ((uart_pkg::HOLD_BITS + 12) * CLKS_PER_BIT) @(negedge uart_clk);
    endtask

    // ==============================
    // tx monitor and watchdog
    // ==============================

    initial begin : tx_monitor
        uart_pkg::byte_t value;
        @(negedge i_rst);
        forever begin
            decode_tx_frame(value);
            tx_seen.push_back(value);
            // rest of the stop bit plus the guard time must stay high
            repeat (HALF_BIT + uart_pkg::HOLD_BITS * CLKS_PER_BIT) begin
                @(negedge uart_clk);
                check_value({15'd0, tx}, 16'h0001, "tx idle between frames");
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge uart_clk);
        $display("Error: the simulation timed out before all tests finished");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    // ==============================
    // main sequence
    // ==============================

    initial begin
        uart_clk = 1'b0;
        i_rst    = 1'b1;
        wb_req   = '0;
        rx       = 1'b1;

        vecs[0] = '{8'hA5, 1'b0, 1'b0, 16'h00A5};
        vecs[1] = '{8'h3C, 1'b0, 1'b0, 16'h003C};
        vecs[2] = '{8'h01, 1'b0, 1'b0, 16'h0001};
        vecs[3] = '{8'h5A, 1'b1, 1'b0, 16'h005A};
        vecs[4] = '{8'hFF, 1'b1, 1'b0, 16'h00FF};
        vecs[5] = '{8'h00, 1'b1, 1'b1, 16'h0006};
        vecs[6] = '{8'h80, 1'b1, 1'b0, 16'h0080};

        repeat (16) @(posedge uart_clk);
        i_rst      <= 1'b0;
        wb_req.cyc <= 1'b1;
        @(negedge uart_clk);
        check_value({15'd0, tx}, 16'h0001, "tx after reset");
        check_value({15'd0, wb_ack}, 16'h0000, "wb_ack with cyc high and stb low");
        expect_read(uart_pkg::ADR_STATUS, 16'h0002, "status after reset");

        for (int i = 0; i < NUM_VECS; i++) begin
            if (!vecs[i].to_rx) begin
                write_reg(uart_pkg::ADR_TX_DATA, {8'd0, vecs[i].data});
                take_tx_byte(b);
                check_value({8'd0, b}, vecs[i].expected, "tx byte from table");
            end else if (vecs[i].bad_stop) begin
                send_rx_frame(vecs[i].data, 1'b1);
                expect_read(uart_pkg::ADR_STATUS, vecs[i].expected, "status after bad stop");
                expect_read(uart_pkg::ADR_RX_DATA, 16'h0000, "rx data after framing error");
                write_reg(uart_pkg::ADR_STATUS, 16'h0000);
                expect_read(uart_pkg::ADR_STATUS, 16'h0002, "status after frame_err clear");
            end else begin
                send_rx_frame(vecs[i].data, 1'b0);
                expect_read(uart_pkg::ADR_STATUS, 16'h0003, "status with rx byte waiting");
                expect_read(uart_pkg::ADR_RX_DATA, vecs[i].expected, "rx byte from table");
                expect_read(uart_pkg::ADR_STATUS, 16'h0002, "status after rx read");
            end
        end

        // tx back-pressure, the idle serializer drains the first byte before the next write
        wait_tx_idle();
        fifo_level = 0;
        for (int i = 0; i < TX_DEPTH + 3; i++) begin
            b = 8'($random(seed));
            write_reg(uart_pkg::ADR_TX_DATA, {8'd0, b});
            if (fifo_level < TX_DEPTH) begin
                expected_q.push_back(b);
                fifo_level++;
            end
            if (i == 0) begin
                fifo_level = 0;
            end
        end
        expect_read(uart_pkg::ADR_STATUS, 16'h0000, "status with tx FIFO full");
        while (expected_q.size() > 0) begin
            take_tx_byte(b);
            check_value({8'd0, b}, {8'd0, expected_q.pop_front()}, "tx byte in write order");
        end
        wait_tx_idle();
        check_value(16'(tx_seen.size()), 16'd0, "count of frames from discarded writes");
        expect_read(uart_pkg::ADR_STATUS, 16'h0002, "status after tx drained");

        // rx overflow keeps only the first RX_DEPTH bytes
        for (int i = 0; i < RX_DEPTH + 2; i++) begin
            b = 8'($random(seed));
            send_rx_frame(b, 1'b0);
            if (i < RX_DEPTH) begin
                expected_q.push_back(b);
            end
        end
        expect_read(uart_pkg::ADR_STATUS, 16'h0003, "status after rx overflow");
        for (int i = 0; i < RX_DEPTH; i++) begin
            expect_read(uart_pkg::ADR_RX_DATA, {8'd0, expected_q[i]}, "rx byte after overflow");
        end
        expect_read(uart_pkg::ADR_RX_DATA, 16'h0000, "read of empty rx FIFO");
        expect_read(uart_pkg::ADR_STATUS, 16'h0002, "status after rx drained");

        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/uart_pkg.sv
verilog/uart_byte_fifo.sv
verilog/uart_bus_regs.sv
verilog/uart_tx_serializer.sv
verilog/uart_rx_deserializer.sv
verilog/uart_top.sv
verification/uart_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = uart_tb
FILELIST  = src.f
BUILD_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)
